// ==== verilog/note_pkg.sv ====
package note_pkg;

    //----------------------------------------------------------------------
    // Widths
    //----------------------------------------------------------------------

    localparam int period_w = 20;  // Lowest C at 50 MHz still fits
    localparam int sample_w = 24;

    //----------------------------------------------------------------------
    // Note encoding
    //----------------------------------------------------------------------

    typedef enum logic [3:0] {
        note_c    = 4'd0,
        note_cs   = 4'd1,
        note_d    = 4'd2,
        note_ds   = 4'd3,
        note_e    = 4'd4,
        note_f    = 4'd5,
        note_fs   = 4'd6,
        note_g    = 4'd7,
        note_gs   = 4'd8,
        note_a    = 4'd9,
        note_as   = 4'd10,
        note_b    = 4'd11,
        note_none = 4'd15
    } note_t;

    //----------------------------------------------------------------------
    // Stage and bus traffic
    //----------------------------------------------------------------------

    typedef struct packed {
        logic                stb;     // New period measured
        logic [period_w-1:0] period;
    } period_s;

    typedef struct packed {
        logic  stb;                   // Classification updated
        note_t note;
    } note_s;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;             // Byte address
        logic [31:0] dat;
    } wb_req_s;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_s;

    // Word indices of the register map
    localparam logic [1:0] reg_status  = 2'd0;
    localparam logic [1:0] reg_period  = 2'd1;
    localparam logic [1:0] reg_changes = 2'd2;

endpackage

// ==== verilog/zero_cross_period.sv ====
`timescale 1ns/1ns

module zero_cross_period
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [note_pkg::sample_w-1:0] mic,
    output note_pkg::period_s             period_out
);

    import note_pkg::*;

    logic                prev_sign;
    logic [period_w-1:0] counter;
    logic                crossing;

    // Sign goes from negative to non-negative
    assign crossing = prev_sign && !mic[sample_w-1];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prev_sign  <= 1'b0;
            counter    <= '0;
            period_out <= '0;
        end
        else
        begin
            prev_sign      <= mic[sample_w-1];
            period_out.stb <= crossing;  // One cycle strobe

            if (crossing)
            begin
                period_out.period <= counter;
                counter           <= '0;
            end
            else if (counter != '1)       // Saturate, no wrap
            begin
                counter <= counter + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/note_classifier.sv ====
`timescale 1ns/1ns

module note_classifier
#(
    parameter int unsigned clk_mhz = 50
)
(
    input  logic              clk,
    input  logic              rst,
    input  note_pkg::period_s period_in,
    output note_pkg::note_s   note_out
);

    import note_pkg::*;

    //----------------------------------------------------------------------
    // Semitone table, hundredths of a Hz, C to B
    //----------------------------------------------------------------------

    localparam int semitones = 12;

    localparam int unsigned freq_100 [semitones] = '{
        26163,  // C
        27718,  // C#
        29366,  // D
        31113,  // D#
        32963,  // E
        34923,  // F
        36999,  // F#
        39200,  // G
        41530,  // G#
        44000,  // A
        46616,  // A#
        49388   // B
    };

    //----------------------------------------------------------------------
    // Window tests
    //----------------------------------------------------------------------

    // Scaled by 100 in the divide, so 97 and 103 give the 3% edges
    function automatic logic in_window
    (
        input int unsigned         f100,
        input logic [period_w-1:0] p
    );
        int unsigned nominal;
        nominal = clk_mhz * 1_000_000 / f100;
        return (p > nominal * 97) && (p < nominal * 103);
    endfunction

    // Three octaves of one semitone
    function automatic logic note_matches
    (
        input int unsigned         f100,
        input logic [period_w-1:0] p
    );
        return in_window(f100, p)
            || in_window(f100 * 2, p)
            || in_window(f100 * 4, p);
    endfunction

    note_t match;

    // Walk downward so the lowest matching semitone wins
    always_comb
    begin
        match = note_none;
        for (int i = semitones - 1; i >= 0; i--)
            if (note_matches(freq_100[i], period_in.period))
                match = note_t'(i);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            note_out.stb  <= 1'b0;
            note_out.note <= note_none;
        end
        else
        begin
            note_out.stb <= period_in.stb;
            if (period_in.stb)
                note_out.note <= match;  // Held between strobes
        end
    end

endmodule

// ==== verilog/note_stabilizer.sv ====
`timescale 1ns/1ns

module note_stabilizer
#(
    parameter int stable_bits = 20
)
(
    input  logic            clk,
    input  logic            rst,
    input  note_pkg::note_s note_in,
    output note_pkg::note_t stable_note
);

    import note_pkg::*;

    note_t                  cur_note;  // Latest classification
    note_t                  d_note;    // Delayed copy
    logic [stable_bits-1:0] run_cnt;   // Cycles without a change

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cur_note    <= note_none;
            d_note      <= note_none;
            run_cnt     <= '0;
            stable_note <= note_none;
        end
        else
        begin
            if (note_in.stb)
                cur_note <= note_in.note;

            d_note <= cur_note;

            if (cur_note != d_note)
                run_cnt <= '0;           // Any flicker restarts the run
            else
                run_cnt <= run_cnt + 1'b1;

            // Full wrap with no difference
            if (&run_cnt)
                stable_note <= d_note;
        end
    end

endmodule

// ==== verilog/note_display.sv ====
`timescale 1ns/1ns

module note_display
(
    input  logic            clk,
    input  logic            rst,
    input  note_pkg::note_t stable_note,
    output logic            note_vld,
    output logic [3:0]      note_idx,
    output logic [7:0]      abcdefgh,
    output logic [15:0]     change_count
);

    import note_pkg::*;

    //      --a--
    //     |     |
    //     f     b
    //      --g--
    //     e     c
    //      --d--  h        h is the dot, lit for sharps

    localparam logic [7:0] dash_seg = 8'b0000_0010;

    note_t shown_note;   // Note currently on the outputs

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            shown_note   <= note_none;
            note_vld     <= 1'b0;
            note_idx     <= 4'd0;
            abcdefgh     <= dash_seg;
            change_count <= '0;
        end
        else
        begin
            shown_note <= stable_note;
            note_vld   <= (stable_note != note_none);

            if (stable_note != note_none)
                note_idx <= stable_note;  // Holds while no note

            if (stable_note != shown_note)
                change_count <= change_count + 1'b1;

            case (stable_note)
                note_c:  abcdefgh <= 8'b1001_1100;
                note_cs: abcdefgh <= 8'b1001_1101;
                note_d:  abcdefgh <= 8'b0111_1010;
                note_ds: abcdefgh <= 8'b0111_1011;
                note_e:  abcdefgh <= 8'b1001_1110;
                note_f:  abcdefgh <= 8'b1000_1110;
                note_fs: abcdefgh <= 8'b1000_1111;
                note_g:  abcdefgh <= 8'b1011_1100;
                note_gs: abcdefgh <= 8'b1011_1101;
                note_a:  abcdefgh <= 8'b1110_1110;
                note_as: abcdefgh <= 8'b1110_1111;
                note_b:  abcdefgh <= 8'b0011_1110;
                default: abcdefgh <= dash_seg;
            endcase
        end
    end

endmodule

// ==== verilog/note_wb_regs.sv ====
`timescale 1ns/1ns

module note_wb_regs
(
    input  logic              clk,
    input  logic              rst,
    input  note_pkg::wb_req_s wb_req,
    output note_pkg::wb_rsp_s wb_rsp,
    input  note_pkg::period_s period_in,
    input  logic              note_vld,
    input  logic [3:0]        note_idx,
    input  logic [15:0]       change_count
);

    import note_pkg::*;

    typedef enum logic {
        wb_idle,
        wb_ack
    } wb_state_t;

    wb_state_t           state;
    logic [31:0]         rsp_dat;
    logic [31:0]         rd_dat;
    logic [period_w-1:0] last_period;

    always_ff @(posedge clk)
    begin
        if (rst)
            last_period <= '0;
        else if (period_in.stb)
            last_period <= period_in.period;
    end

    // Word select from the byte address
    always_comb
    begin
        case (wb_req.adr[3:2])
            reg_status:  rd_dat = {27'd0, note_vld, note_idx};
            reg_period:  rd_dat = {{(32 - period_w){1'b0}}, last_period};
            reg_changes: rd_dat = {16'd0, change_count};
            default:     rd_dat = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= wb_idle;
            rsp_dat <= '0;
        end
        else if (state == wb_ack)
        begin
            state <= wb_idle;                      // Never two acks in a row
        end
        else if (wb_req.cyc && wb_req.stb)
        begin
            state   <= wb_ack;
            rsp_dat <= wb_req.we ? '0 : rd_dat;    // Writes are dropped
        end
    end

    assign wb_rsp = '{ack: (state == wb_ack), dat: rsp_dat};

endmodule

// ==== verilog/note_recognizer_top.sv ====
`timescale 1ns/1ns

module note_recognizer_top
#(
    parameter int unsigned clk_mhz     = 50,
    parameter int          stable_bits = 20
)
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic [note_pkg::sample_w-1:0] mic,
    input  note_pkg::wb_req_s             wb_req,
    output note_pkg::wb_rsp_s             wb_rsp,
    output logic                          note_vld,
    output logic [3:0]                    note_idx,
    output logic [7:0]                    abcdefgh
);

    import note_pkg::*;

    //----------------------------------------------------------------------
    // Internal stage signals
    //----------------------------------------------------------------------

    period_s     period;        // Crossing period with strobe
    note_s       raw_note;      // Per-period classification
    note_t       stable_note;
    logic [15:0] change_count;

    //----------------------------------------------------------------------
    // Datapath
    //----------------------------------------------------------------------

    zero_cross_period zcp0 (
        .clk        (clk),
        .rst        (rst),
        .mic        (mic),
        .period_out (period)
    );

    note_classifier #(.clk_mhz(clk_mhz)) cls0 (
        .clk       (clk),
        .rst       (rst),
        .period_in (period),
        .note_out  (raw_note)
    );

    note_stabilizer #(.stable_bits(stable_bits)) stab0 (
        .clk         (clk),
        .rst         (rst),
        .note_in     (raw_note),
        .stable_note (stable_note)
    );

    note_display disp0 (
        .clk          (clk),
        .rst          (rst),
        .stable_note  (stable_note),
        .note_vld     (note_vld),
        .note_idx     (note_idx),
        .abcdefgh     (abcdefgh),
        .change_count (change_count)
    );

    // Host access to status, period and change count
    note_wb_regs regs0 (
        .clk          (clk),
        .rst          (rst),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .period_in    (period),
        .note_vld     (note_vld),
        .note_idx     (note_idx),
        .change_count (change_count)
    );

endmodule

// ==== test/note_recognizer_assertions.sv ====
`timescale 1ns/1ns

module note_recognizer_assertions
(
    input logic              clk,
    input logic              rst,
    input note_pkg::wb_req_s wb_req,
    input note_pkg::wb_rsp_s wb_rsp,
    input logic              note_vld,
    input logic [7:0]        abcdefgh
);

    localparam logic [7:0] dash_seg = 8'b0000_0010;  // Segment g only

    //----------------------------------------------------------------------
    // Wishbone slave
    //----------------------------------------------------------------------

    ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack high in two cycles running");

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> wb_req.cyc)
        else $error("ack outside a bus cycle");

    // A valid note never shows the dash
    vld_shows_note: assert property (@(posedge clk) disable iff (rst)
        note_vld |-> abcdefgh != dash_seg)
        else $error("note_vld high with the dash pattern");

endmodule

bind note_recognizer_top note_recognizer_assertions asrt0 (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .note_vld (note_vld),
    .abcdefgh (abcdefgh)
);

// ==== test/tb_note_recognizer.sv ====
`timescale 1ns/1ns

module tb_note_recognizer;

    import note_pkg::*;

    localparam int unsigned clk_mhz     = 1;
    localparam int          stable_bits = 12;
    localparam int          wait_limit  = 40000;     // Cycles per display wait
    localparam logic [7:0]  dash_seg    = 8'b0000_0010;
    localparam logic [sample_w-1:0] mic_low  = 24'hC2F700;  // About -4e6
    localparam logic [sample_w-1:0] mic_high = 24'h3D0900;  // About +4e6

    // Semitones C to B, hundredths of a Hz
    localparam int unsigned freq_100 [12] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    // Letter shape plus dot for sharps, bits a b c d e f g h
    localparam logic [7:0] seg_tab [12] = '{
        8'b1001_1100, 8'b1001_1101, 8'b0111_1010, 8'b0111_1011,
        8'b1001_1110, 8'b1000_1110, 8'b1000_1111, 8'b1011_1100,
        8'b1011_1101, 8'b1110_1110, 8'b1110_1111, 8'b0011_1110
    };

    logic                clk;
    logic                rst;
    logic [sample_w-1:0] mic;
    wb_req_s             wb_req;
    wb_rsp_s             wb_rsp;
    logic                note_vld;
    logic [3:0]          note_idx;
    logic [7:0]          abcdefgh;

    logic [31:0] lfsr = 32'hd473a132;
    int          drive_len = 5001;     // Full wave period in cycles
    int          gen_pos;
    int          gen_len;
    logic [4:0]  prev_disp;            // Last {note_vld, note_idx}
    int          seen_changes;
    int          changes_at_ack;
    int          errors = 0;

    note_recognizer_top #(.clk_mhz(clk_mhz), .stable_bits(stable_bits)) dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Random bits and reference model
    //----------------------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic int unsigned take_bits(input int n);
        int unsigned r;
        logic        fb;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int unsigned nominal(input int unsigned f100);
        return clk_mhz * 1_000_000 / f100;
    endfunction

    // Open 3% window around a nominal scaled by 100
    function automatic bit in_band(input int unsigned f100, input int unsigned p);
        return (p > nominal(f100) * 97) && (p < nominal(f100) * 103);
    endfunction

    // First semitone in C to B order, 15 when no window holds p
    function automatic int model_note(input int unsigned p);
        int result;
        result = 15;
        for (int s = 0; s < 12; s++)
            for (int oct = 0; oct < 3; oct++)
                if (result == 15 && in_band(freq_100[s] << oct, p))
                    result = s;
        return result;
    endfunction

    //----------------------------------------------------------------------
    // Checks, bus access and waits
    //----------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("No %s within the time limit", what);
        $display("Something failed");
        $fatal(1, "Timeout");
    endtask

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        for (n = 1; !wb_rsp.ack && n < 20; n++)
            @(negedge clk);
        if (!wb_rsp.ack)
            give_up("Wishbone ack");
        rdat           = wb_rsp.dat;
        changes_at_ack = seen_changes;
        @(negedge clk);                  // Hold through the edge that samples ack
        wb_req = '0;
    endtask

    task automatic wait_vld(input logic level);
        int n;
        n = 0;
        while (note_vld !== level && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (note_vld !== level)
            give_up(level ? "rise of note_vld" : "fall of note_vld");
    endtask

    // Square wave, negative half first, length taken at each period start
    initial
    begin
        mic     = '0;
        gen_pos = 0;
        gen_len = drive_len;
        forever
        begin
            @(negedge clk);
            if (gen_pos == 0)
                gen_len = drive_len;
            mic     = (gen_pos < gen_len / 2) ? mic_low : mic_high;
            gen_pos = (gen_pos + 1 == gen_len) ? 0 : gen_pos + 1;
        end
    end

    // Display changes as seen at the ports
    always @(negedge clk)
    begin
        if (rst)
        begin
            prev_disp    <= 5'd0;
            seen_changes <= 0;
        end
        else if ({note_vld, note_idx} != prev_disp)
        begin
            prev_disp    <= {note_vld, note_idx};
            seen_changes <= seen_changes + 1;
        end
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------

    initial
    begin
        logic [31:0] d;
        logic [31:0] status_before;
        int          sem;
        int          oct;
        int unsigned target;
        int unsigned off;
        int          exp_idx;
        int          tries;

        rst    = 1'b1;
        wb_req = '0;
        repeat (10)
            @(negedge clk);
        rst = 1'b0;

        check_value("note_vld", note_vld, 0);
        check_value("note_idx", note_idx, 0);
        check_value("abcdefgh", abcdefgh, dash_seg);
        wb_access(1'b0, 4'h8, '0, d);
        check_value("reg_changes", d, 0);

        for (int k = 0; k < 10; k++)
        begin
            sem       = take_bits(8) % 12;
            oct       = take_bits(4) % 3;
            target    = nominal(freq_100[sem] << oct) * 100;
            exp_idx   = model_note(target);
            drive_len <= target + 1;     // Counter restarts on the crossing, so one less
            wait_vld(1'b1);
            check_value("note_idx", note_idx, exp_idx);
            check_value("abcdefgh", abcdefgh, seg_tab[exp_idx]);
            wb_access(1'b0, 4'h4, '0, d);
            check_value("reg_period", d, target);
            wb_access(1'b0, 4'h0, '0, d);
            check_value("reg_status", d, {27'd0, 1'b1, 4'(exp_idx)});
            wb_access(1'b0, 4'h8, '0, d);
            check_value("reg_changes", d, changes_at_ack);

            // Halfway between two neighbouring semitones
            tries = 0;
            do
            begin
                sem = take_bits(8) % 11;
                oct = take_bits(4) % 3;
                off = (nominal(freq_100[sem] << oct) + nominal(freq_100[sem + 1] << oct)) * 50;
                tries++;
            end
            while (model_note(off) != 15 && tries < 50);
            if (model_note(off) != 15)
                off = 2900;              // Gap between E and F, lowest octave
            drive_len <= off + 1;
            wait_vld(1'b0);
            check_value("abcdefgh", abcdefgh, dash_seg);
            check_value("note_idx", note_idx, exp_idx);
        end

        wb_access(1'b0, 4'hC, '0, d);
        check_value("reg_unmapped", d, 0);
        wb_access(1'b0, 4'h0, '0, status_before);
        wb_access(1'b1, 4'h0, take_bits(32), d);
        wb_access(1'b0, 4'h0, '0, d);
        check_value("reg_status", d, status_before);
        wb_access(1'b0, 4'h8, '0, d);
        check_value("reg_changes", d, changes_at_ack);

        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== src.f ====
verilog/note_pkg.sv
verilog/zero_cross_period.sv
verilog/note_classifier.sv
verilog/note_stabilizer.sv
verilog/note_display.sv
verilog/note_wb_regs.sv
verilog/note_recognizer_top.sv
test/note_recognizer_assertions.sv
test/tb_note_recognizer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the note recognizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_note_recognizer -f src.f -o sim_note

status=0
./obj_dir/sim_note > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
    echo "Simulation did not pass"
    exit 1
fi
echo "Simulation passed"
